/* tb.f */
+incdir+verilog
verilog/vfx_pkg.sv
verilog/vsmul.sv
verilog/vmul_seq.sv
verilog/vsmul_step_counter.sv
verilog/vsmul_ctrl.sv
verilog/vsmul_unit.sv
verification/vsmul_props.sv
verification/vsmul_tb.sv

/* verification/vsmul_tb.sv */
`include "vsmul_consts.svh"

module vsmul_tb;

    localparam int RESET_CYC   = 5;
    localparam int NUM_REQ     = 47; // 32 random, 8 rounding, 5 saturation, 2 back-pressure.
    localparam int TIMEOUT_CYC = 20 * NUM_REQ + RESET_CYC;

    logic                      clk_i;
    logic                      rst_n_i;
    logic                      req_i;
    vfx_pkg::sew_t             sew_i;
    vfx_pkg::vxrm_t            vxrm_i;
    logic [`VSMUL_SLICE_W-1:0] vs1_i;
    logic [`VSMUL_SLICE_W-1:0] vs2_i;
    logic                      vxsat_clr_i;
    logic                      ack_o;
    logic [`VSMUL_SLICE_W-1:0] result_o;
    logic                      vxsat_o;

    int   seed = 74125;
    int   cycles = 0;
    logic exp_vxsat = 1'b0; // sticky flag as the model sees it.

    vsmul_unit dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYC);
            $display("SOME TESTS FAILED");
            $fatal(1, "simulation stopped on timeout");
        end
    end

    task automatic check(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, act, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic signed [127:0] sext(input logic [63:0] x, input int w);
        logic signed [127:0] v;
        v = '0;
        for (int k = 0; k < w; k++) v[k] = x[k];
        if (x[w-1]) v = v - (128'sd1 <<< w); // two's complement value of the element.
        return v;
    endfunction

    // Returns {saturated, result} for a whole slice.
    function automatic logic [64:0] ref_vsmul(input vfx_pkg::sew_t sew,
                                              input vfx_pkg::vxrm_t mode,
                                              input logic [63:0] vs1, input logic [63:0] vs2);
        int                  w;
        logic signed [127:0] p;
        logic signed [127:0] q;
        logic signed [127:0] pos_max;
        logic [127:0]        low;
        logic                rest;
        logic                rnd;
        logic [63:0]         res;
        logic                sat;
        w   = 8 << sew;
        res = '0;
        sat = 1'b0;
        pos_max = (128'sd1 <<< (w - 1)) - 128'sd1;
        for (int e = 0; e < 64 / w; e++) begin
            p    = sext(vs2 >> (e * w), w) * sext(vs1 >> (e * w), w);
            low  = p & ((128'd1 << (w - 1)) - 128'd1);  // all discarded bits.
            rest = (p & ((128'd1 << (w - 2)) - 128'd1)) != 0;
            case (mode)
                vfx_pkg::RNU_V: rnd = p[w-2];
                vfx_pkg::RNE_V: rnd = p[w-2] & (rest | p[w-1]);
                default:        rnd = 1'b0;
            endcase
            q = (p >>> (w - 1)) + $signed({1'b0, rnd});
            if (mode == vfx_pkg::ROD_V && !q[0] && low != 0) q[0] = 1'b1;
            if (q > pos_max) begin
                q   = pos_max;
                sat = 1'b1;
            end
            for (int k = 0; k < w; k++) res[e*w+k] = q[k];
        end
        return {sat, res};
    endfunction

    // Full four-phase handshake, holding req_i for hold extra cycles after ack_o.
    task automatic run_request(input vfx_pkg::sew_t sew, input vfx_pkg::vxrm_t mode,
                               input logic [63:0] a, input logic [63:0] b, input int hold);
        logic [64:0] exp;
        exp = ref_vsmul(sew, mode, a, b);
        exp_vxsat = exp_vxsat | exp[64];
        @(negedge clk_i);
        sew_i  = sew;
        vxrm_i = mode;
        vs1_i  = a;
        vs2_i  = b;
        req_i  = 1'b1;
        while (!ack_o) @(negedge clk_i);
        check("result_o", result_o, exp[63:0]);
        check("vxsat_o", 64'(vxsat_o), 64'(exp_vxsat));
        repeat (hold) begin
            @(negedge clk_i);
            check("ack_o", 64'(ack_o), 64'd1);
            check("result_o", result_o, exp[63:0]);
        end
        @(negedge clk_i);
        req_i = 1'b0;
        while (ack_o) @(negedge clk_i);
    endtask

    task automatic clear_vxsat();
        @(negedge clk_i);
        vxsat_clr_i = 1'b1;
        @(negedge clk_i);
        vxsat_clr_i = 1'b0;
        exp_vxsat   = 1'b0;
        check("vxsat_o", 64'(vxsat_o), 64'd0);
    endtask

    task automatic reset_state_values();
        check("ack_o", 64'(ack_o), 64'd0);
        check("vxsat_o", 64'(vxsat_o), 64'd0);
        check("result_o", result_o, 64'd0);
    endtask

    task automatic sweep_sew_modes();
        for (int s = 0; s < 4; s++) begin
            for (int m = 0; m < 4; m++) begin
                repeat (2) begin
                    run_request(vfx_pkg::sew_t'(s), vfx_pkg::vxrm_t'(m),
                                {$random(seed), $random(seed)},
                                {$random(seed), $random(seed)}, 0);
                end
            end
        end
    endtask

    // Discarded bits at exactly one half, with odd, even and negative kept parts.
    task automatic rounding_corners();
        for (int m = 0; m < 4; m++) begin
            run_request(vfx_pkg::SEW_8, vfx_pkg::vxrm_t'(m),
                        64'h0000_0000_0040_4040, 64'h0000_0000_00fd_0503, 0);
            run_request(vfx_pkg::SEW_16, vfx_pkg::vxrm_t'(m),
                        64'h7fff_4000_4000_4000, 64'h7fff_fffd_0005_0003, 0);
        end
    endtask

    task automatic saturation_and_sticky();
        clear_vxsat();
        run_request(vfx_pkg::SEW_8, vfx_pkg::RNU_V,
                    64'h1234_5678_8000_9abc, 64'h4321_8765_8000_0123, 0);
        check("vxsat_o", 64'(vxsat_o), 64'd1);
        clear_vxsat();
        run_request(vfx_pkg::SEW_16, vfx_pkg::RNE_V,
                    64'h1234_5678_8000_9abc, 64'h4321_8765_8000_0123, 0);
        clear_vxsat();
        run_request(vfx_pkg::SEW_32, vfx_pkg::RDN_V,
                    64'h8000_0000_1234_5678, 64'h8000_0000_8765_4321, 0);
        clear_vxsat();
        run_request(vfx_pkg::SEW_64, vfx_pkg::ROD_V,
                    64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000, 0);
        run_request(vfx_pkg::SEW_32, vfx_pkg::RNU_V,
                    64'h0000_0003_0000_0005, 64'h0000_0007_0000_0009, 0);
        check("vxsat_o", 64'(vxsat_o), 64'd1); // still set after a clean request.
        clear_vxsat();
    endtask

    task automatic back_pressure_hold();
        run_request(vfx_pkg::SEW_16, vfx_pkg::RNE_V,
                    {$random(seed), $random(seed)}, {$random(seed), $random(seed)}, 6);
        run_request(vfx_pkg::SEW_64, vfx_pkg::RNU_V,
                    {$random(seed), $random(seed)}, {$random(seed), $random(seed)}, 0);
    endtask

    initial begin
        rst_n_i     = 1'b0;
        req_i       = 1'b0;
        sew_i       = vfx_pkg::SEW_8;
        vxrm_i      = vfx_pkg::RNU_V;
        vs1_i       = '0;
        vs2_i       = '0;
        vxsat_clr_i = 1'b0;
        repeat (RESET_CYC) @(negedge clk_i);
        rst_n_i = 1'b1;
        reset_state_values();
        sweep_sew_modes();
        rounding_corners();
        saturation_and_sticky();
        back_pressure_hold();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* verification/vsmul_props.sv */
`include "vsmul_consts.svh"

module vsmul_props (
    input logic                      clk_i,
    input logic                      rst_n_i,
    input logic                      req_i,
    input vfx_pkg::sew_t             sew_i,
    input logic                      ack_o,
    input logic [`VSMUL_SLICE_W-1:0] result_o
);

    // ack_o changes on the edge SEW/8+2 after acceptance and is seen one sample later.
    a_lat_8: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(req_i) && sew_i == vfx_pkg::SEW_8 |-> ##4 $rose(ack_o))
        else $error("ack_o latency wrong at SEW 8");
    a_lat_16: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(req_i) && sew_i == vfx_pkg::SEW_16 |-> ##5 $rose(ack_o))
        else $error("ack_o latency wrong at SEW 16");
    a_lat_32: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(req_i) && sew_i == vfx_pkg::SEW_32 |-> ##7 $rose(ack_o))
        else $error("ack_o latency wrong at SEW 32");
    a_lat_64: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(req_i) && sew_i == vfx_pkg::SEW_64 |-> ##11 $rose(ack_o))
        else $error("ack_o latency wrong at SEW 64");

    a_ack_fall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_o && !req_i |=> !ack_o) else $error("ack_o did not fall after req_i fell");

    a_result_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_o |=> $stable(result_o)) else $error("result_o changed while ack_o was high");

endmodule

bind vsmul_unit vsmul_props u_props (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .req_i    (req_i),
    .sew_i    (sew_i),
    .ack_o    (ack_o),
    .result_o (result_o)
);

/* verilog/vsmul_unit.sv */
`include "vsmul_consts.svh"

module vsmul_unit (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       req_i,
    input  vfx_pkg::sew_t              sew_i,
    input  vfx_pkg::vxrm_t             vxrm_i,
    input  logic [`VSMUL_SLICE_W-1:0]  vs1_i,
    input  logic [`VSMUL_SLICE_W-1:0]  vs2_i,
    input  logic                       vxsat_clr_i,
    output logic                       ack_o,
    output logic [`VSMUL_SLICE_W-1:0]  result_o,
    output logic                       vxsat_o
);

    logic                      mul_load;
    logic                      mul_step;
    logic                      step_last;
    logic [`VSMUL_PROD_W-1:0]  product;
    logic [`VSMUL_SLICE_W-1:0] data_vd;
    logic                      sat_ovf;

    vsmul_ctrl u_ctrl (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .step_last_i (step_last),
        .data_vd_i   (data_vd),
        .sat_ovf_i   (sat_ovf),
        .vxsat_clr_i (vxsat_clr_i),
        .mul_load_o  (mul_load),
        .mul_step_o  (mul_step),
        .ack_o       (ack_o),
        .result_o    (result_o),
        .vxsat_o     (vxsat_o)
    );

    vsmul_step_counter u_step_counter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .sew_i       (sew_i),
        .clear_i     (mul_load),
        .inc_i       (mul_step),
        .step_last_o (step_last)
    );

    vmul_seq u_mul (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .sew_i     (sew_i),
        .load_i    (mul_load),
        .step_i    (mul_step),
        .vs1_i     (vs1_i),
        .vs2_i     (vs2_i),
        .product_o (product)
    );

    vsmul u_round (
        .sew_i     (sew_i),
        .vxrm_i    (vxrm_i),
        .data_i    (product),
        .data_vd_o (data_vd),
        .sat_ovf_o (sat_ovf)
    );

endmodule

/* verilog/vsmul_ctrl.sv */
`include "vsmul_consts.svh"

module vsmul_ctrl (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  logic                       req_i,
    input  logic                       step_last_i,
    input  logic [`VSMUL_SLICE_W-1:0]  data_vd_i,
    input  logic                       sat_ovf_i,
    input  logic                       vxsat_clr_i,
    output logic                       mul_load_o,
    output logic                       mul_step_o,
    output logic                       ack_o,
    output logic [`VSMUL_SLICE_W-1:0]  result_o,
    output logic                       vxsat_o
);

    typedef enum logic [1:0] {IDLE, LOAD, STEP, DONE} state_t;

    state_t                    state_q;
    state_t                    state_d;
    logic                      ack_q;
    logic                      vxsat_q;
    logic                      capture;
    logic [`VSMUL_SLICE_W-1:0] result_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (req_i) state_d = LOAD;
            LOAD: state_d = STEP;
            STEP: if (step_last_i) state_d = DONE;
            default: if (ack_q && !req_i) state_d = IDLE;
        endcase
    end

    // The product is complete one cycle after the last step edge.
    assign capture = (state_q == DONE) && !ack_q;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q  <= IDLE;
            ack_q    <= 1'b0;
            result_q <= '0;
        end else begin
            state_q <= state_d;
            if (capture) begin
                ack_q    <= 1'b1;
                result_q <= data_vd_i;
            end else if (state_d == IDLE) begin
                ack_q <= 1'b0;
            end
        end
    end

    // Sticky saturation flag. A clear wins over a set in the same cycle.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i || vxsat_clr_i) begin
            vxsat_q <= 1'b0;
        end else if (capture && sat_ovf_i) begin
            vxsat_q <= 1'b1;
        end
    end

    assign mul_load_o = (state_q == LOAD);
    assign mul_step_o = (state_q == STEP);
    assign ack_o      = ack_q;
    assign result_o   = result_q;
    assign vxsat_o    = vxsat_q;

endmodule

/* verilog/vsmul_step_counter.sv */
`include "vsmul_consts.svh"

module vsmul_step_counter (
    input  logic          clk_i,
    input  logic          rst_n_i,
    input  vfx_pkg::sew_t sew_i,
    input  logic          clear_i,
    input  logic          inc_i,
    output logic          step_last_o
);

    localparam int CNT_W = $clog2(`VSMUL_MAX_STEPS);

    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] last_cnt;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || clear_i) begin
            cnt_q <= '0;
        end else if (inc_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_comb begin
        case (sew_i)
            vfx_pkg::SEW_8:  last_cnt = CNT_W'(0);
            vfx_pkg::SEW_16: last_cnt = CNT_W'(1);
            vfx_pkg::SEW_32: last_cnt = CNT_W'(3);
            default:         last_cnt = CNT_W'(`VSMUL_MAX_STEPS - 1);
        endcase
    end

    assign step_last_o = (cnt_q == last_cnt); // one step per multiplier byte.

endmodule

/* verilog/vmul_seq.sv */
`include "vsmul_consts.svh"

module vmul_seq (
    input  logic                       clk_i,
    input  logic                       rst_n_i,
    input  vfx_pkg::sew_t              sew_i,
    input  logic                       load_i,    // capture operands and clear the sums.
    input  logic                       step_i,    // consume one multiplier byte.
    input  logic [`VSMUL_SLICE_W-1:0]  vs1_i,
    input  logic [`VSMUL_SLICE_W-1:0]  vs2_i,
    output logic [`VSMUL_PROD_W-1:0]   product_o
);

    logic [`VSMUL_SLICE_W-1:0] mcand_q;   // multiplicand elements.
    logic [`VSMUL_SLICE_W-1:0] mplier_q;  // multiplier elements, top byte consumed first.
    logic [`VSMUL_SLICE_W-1:0] mplier_d;
    logic [`VSMUL_PROD_W-1:0]  acc_q;
    logic [`VSMUL_PROD_W-1:0]  acc_d;
    logic                      first_q;   // the current byte is the signed top byte.

    // Signed multiplicand of width w times one multiplier byte.
    function automatic logic [`VSMUL_PROD_W-1:0] lane_pp(input logic [`VSMUL_SLICE_W-1:0] mcand,
                                                        input logic [7:0] digit,
                                                        input logic top,
                                                        input int unsigned w);
        logic signed [`VSMUL_SLICE_W-1:0] a;
        logic signed [8:0]                b;
        logic signed [`VSMUL_PROD_W-1:0]  p;
        a = $signed(mcand << (`VSMUL_SLICE_W - w)) >>> (`VSMUL_SLICE_W - w);
        b = {top & digit[7], digit};
        p = a * b;
        lane_pp = p;
    endfunction

    // Horner form: each step shifts the sum one byte up and adds the next partial product.
    always_comb begin
        acc_d    = acc_q;
        mplier_d = mplier_q;
        case (sew_i)
            vfx_pkg::SEW_8: begin
                for (int i = 0; i < `VSMUL_LANES; i++) begin
                    acc_d[16*i +: 16] = (acc_q[16*i +: 16] << 8)
                        + 16'(lane_pp(mcand_q[8*i +: 8], mplier_q[8*i +: 8], first_q, 8));
                    mplier_d[8*i +: 8] = mplier_q[8*i +: 8] << 8;
                end
            end
            vfx_pkg::SEW_16: begin
                for (int i = 0; i < `VSMUL_LANES/2; i++) begin
                    acc_d[32*i +: 32] = (acc_q[32*i +: 32] << 8)
                        + 32'(lane_pp(mcand_q[16*i +: 16], mplier_q[16*i+8 +: 8], first_q, 16));
                    mplier_d[16*i +: 16] = mplier_q[16*i +: 16] << 8;
                end
            end
            vfx_pkg::SEW_32: begin
                for (int i = 0; i < `VSMUL_LANES/4; i++) begin
                    acc_d[64*i +: 64] = (acc_q[64*i +: 64] << 8)
                        + 64'(lane_pp(mcand_q[32*i +: 32], mplier_q[32*i+24 +: 8], first_q, 32));
                    mplier_d[32*i +: 32] = mplier_q[32*i +: 32] << 8;
                end
            end
            default: begin
                acc_d    = (acc_q << 8) + lane_pp(mcand_q, mplier_q[63:56], first_q, 64);
                mplier_d = mplier_q << 8;
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            first_q <= 1'b0;
        end else if (load_i) begin
            first_q <= 1'b1;
        end else if (step_i) begin
            first_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_i) begin
            mcand_q  <= vs2_i;
            mplier_q <= vs1_i;
            acc_q    <= '0;
        end else if (step_i) begin
            mplier_q <= mplier_d;
            acc_q    <= acc_d;
        end
    end

    assign product_o = acc_q; // exact after SEW/8 steps.

endmodule

/* verilog/vsmul.sv */
`include "vsmul_consts.svh"

module vsmul (
    input  vfx_pkg::sew_t              sew_i,
    input  vfx_pkg::vxrm_t             vxrm_i,
    input  logic [`VSMUL_PROD_W-1:0]   data_i,    // element products at twice SEW.
    output logic [`VSMUL_SLICE_W-1:0]  data_vd_o, // rounded and saturated result.
    output logic                       sat_ovf_o  // some element saturated.
);

    logic [`VSMUL_LANES-1:0][7:0] kept;      // product bits SEW-1 and up, per byte lane.
    logic [`VSMUL_LANES-1:0][7:0] sum;
    logic [`VSMUL_LANES-1:0]      first;     // lowest lane of an element.
    logic [`VSMUL_LANES-1:0]      pos_top;   // top lane of an element with a positive product.
    logic [`VSMUL_LANES-1:0]      rinc;      // rounding increment, only in first lanes.
    logic [`VSMUL_LANES-1:0]      carry_in;
    logic [`VSMUL_LANES-1:0]      carry_out;
    logic [`VSMUL_LANES-1:0]      ovf;

    // Rounding increment for one element whose product sits at bit 0 of prod.
    function automatic logic round_bit(input vfx_pkg::vxrm_t mode,
                                       input logic [`VSMUL_PROD_W-1:0] prod,
                                       input int unsigned w);
        logic lsb;
        logic half;
        logic rest;
        lsb  = prod[w-1];  // lowest kept bit.
        half = prod[w-2];  // weight of one half.
        rest = (prod & ((`VSMUL_PROD_W'(1) << (w - 2)) - `VSMUL_PROD_W'(1))) != '0;
        case (mode)
            vfx_pkg::RNU_V: round_bit = half;
            vfx_pkg::RNE_V: round_bit = half & (rest | lsb);
            vfx_pkg::RDN_V: round_bit = 1'b0;
            default:        round_bit = ~lsb & (half | rest);
        endcase
    endfunction

    // The product has two sign bits, so SEW bits from bit SEW-1 upward carry the value.
    always_comb begin
        kept    = '0;
        first   = '0;
        pos_top = '0;
        rinc    = '0;
        case (sew_i)
            vfx_pkg::SEW_8: begin
                for (int i = 0; i < `VSMUL_LANES; i++) begin
                    kept[i]    = data_i[16*i+7 +: 8];
                    first[i]   = 1'b1;
                    pos_top[i] = ~data_i[16*i+15];
                    rinc[i]    = round_bit(vxrm_i, data_i >> (16*i), 8);
                end
            end
            vfx_pkg::SEW_16: begin
                for (int i = 0; i < `VSMUL_LANES/2; i++) begin
                    kept[2*i +: 2]   = data_i[32*i+15 +: 16];
                    first[2*i]       = 1'b1;
                    pos_top[2*i+1]   = ~data_i[32*i+31];
                    rinc[2*i]        = round_bit(vxrm_i, data_i >> (32*i), 16);
                end
            end
            vfx_pkg::SEW_32: begin
                for (int i = 0; i < `VSMUL_LANES/4; i++) begin
                    kept[4*i +: 4]   = data_i[64*i+31 +: 32];
                    first[4*i]       = 1'b1;
                    pos_top[4*i+3]   = ~data_i[64*i+63];
                    rinc[4*i]        = round_bit(vxrm_i, data_i >> (64*i), 32);
                end
            end
            default: begin
                kept       = data_i[126:63];
                first[0]   = 1'b1;
                pos_top[7] = ~data_i[127];
                rinc[0]    = round_bit(vxrm_i, data_i, 64);
            end
        endcase
    end

    // Byte-lane incrementer. The chain restarts at the first lane of every element.
    always_comb begin
        carry_in[0] = rinc[0];
        {carry_out[0], sum[0]} = {1'b0, kept[0]} + 9'(carry_in[0]);
        for (int j = 1; j < `VSMUL_LANES; j++) begin
            carry_in[j] = first[j] ? rinc[j] : carry_out[j-1];
            {carry_out[j], sum[j]} = {1'b0, kept[j]} + 9'(carry_in[j]);
        end
    end

    // A positive product whose result reads negative has overflowed.
    always_comb begin
        for (int j = 0; j < `VSMUL_LANES; j++) begin
            ovf[j] = pos_top[j] & sum[j][7];
        end
    end

    always_comb begin
        data_vd_o = sum;
        case (sew_i)
            vfx_pkg::SEW_8: begin
                for (int i = 0; i < `VSMUL_LANES; i++) begin
                    data_vd_o[8*i +: 8] = ovf[i] ? 8'h7f : sum[i];
                end
            end
            vfx_pkg::SEW_16: begin
                for (int i = 0; i < `VSMUL_LANES/2; i++) begin
                    data_vd_o[16*i +: 16] = ovf[2*i+1] ? 16'h7fff : sum[2*i +: 2];
                end
            end
            vfx_pkg::SEW_32: begin
                for (int i = 0; i < `VSMUL_LANES/4; i++) begin
                    data_vd_o[32*i +: 32] = ovf[4*i+3] ? 32'h7fff_ffff : sum[4*i +: 4];
                end
            end
            default: begin
                data_vd_o = ovf[7] ? 64'h7fff_ffff_ffff_ffff : sum;
            end
        endcase
        sat_ovf_o = |ovf; // only top lanes can flag.
    end

endmodule

/* verilog/vfx_pkg.sv */
package vfx_pkg;

    // Element width codes, same encoding as vsew.
    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

    // Fixed-point rounding modes in vxrm encoding.
    typedef enum logic [1:0] {
        RNU_V = 2'b00, // round to nearest, ties up.
        RNE_V = 2'b01, // round to nearest, ties to even.
        RDN_V = 2'b10, // truncate toward minus infinity.
        ROD_V = 2'b11  // jam the discarded bits into the lowest bit.
    } vxrm_t;

endpackage

/* verilog/vsmul_consts.svh */
`ifndef VSMUL_CONSTS_SVH
`define VSMUL_CONSTS_SVH

// One operand or result slice of the vector register.
`define VSMUL_SLICE_W 64

// Double-width product bus, two bits per element bit.
`define VSMUL_PROD_W 128

`define VSMUL_LANES 8 // byte lanes in one slice.

// Multiplier steps for SEW 64. The step counter width follows from it.
`define VSMUL_MAX_STEPS 8

`endif
